// ==== hw/ctrl_pkg.sv ====
// #####################################
// Cluster control package
// Sizes, register map and AXI-Lite types
// #####################################

`default_nettype none

package ctrl_pkg;

  // Bus and register sizes
  localparam int unsigned DataWidth = 32;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned NumRegs   = 5;
  localparam int unsigned NumBytes  = 4;
  localparam int unsigned NumCores  = 8;

  // Shared memory placement
  localparam logic [DataWidth-1:0] TcdmBaseAddr = 32'h1000_0000;
  localparam logic [DataWidth-1:0] TcdmSize     = 32'h0001_0000;

  // Register index, byte address is four times the index
  typedef enum logic [2:0] {
    REG_EOC        = 3'd0,
    REG_WAKE_UP    = 3'd1,
    REG_TCDM_START = 3'd2,
    REG_TCDM_END   = 3'd3,
    REG_NUM_CORES  = 3'd4
  } ctrl_reg_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axi_resp_e;

  // Master to slave
  typedef struct packed {
    logic [AddrWidth-1:0] aw_addr;
    logic                 aw_valid;
    logic [DataWidth-1:0] w_data;
    logic [NumBytes-1:0]  w_strb;
    logic                 w_valid;
    logic                 b_ready;
    logic [AddrWidth-1:0] ar_addr;
    logic                 ar_valid;
    logic                 r_ready;
  } axi_lite_req_t;

  // Slave to master
  typedef struct packed {
    logic                 aw_ready;
    logic                 w_ready;
    axi_resp_e            b_resp;
    logic                 b_valid;
    logic                 ar_ready;
    logic [DataWidth-1:0] r_data;
    axi_resp_e            r_resp;
    logic                 r_valid;
  } axi_lite_resp_t;

  // Reset contents, highest register first
  localparam logic [NumRegs-1:0][DataWidth-1:0] RegRstVal = '{
    DataWidth'(NumCores),
    TcdmBaseAddr + TcdmSize,
    TcdmBaseAddr,
    {DataWidth{1'b0}},
    {DataWidth{1'b0}}
  };

  // Start, end and core count are read-only
  localparam logic [NumRegs-1:0][NumBytes-1:0] RegReadOnly = '{
    {NumBytes{1'b1}},
    {NumBytes{1'b1}},
    {NumBytes{1'b1}},
    {NumBytes{1'b0}},
    {NumBytes{1'b0}}
  };

endpackage

`default_nettype wire

// ==== hw/axi_lite_regs.sv ====
// #####################################
// AXI-Lite register slave
// Byte-addressed registers with read-only
// masks and per-byte write strobes out
// #####################################

`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs (
  input  logic                                             clk_i,
  input  logic                                             reset_i,
  input  ctrl_pkg::axi_lite_req_t                          axi_req_i,
  output ctrl_pkg::axi_lite_resp_t                         axi_resp_o,
  output logic [ctrl_pkg::NumRegs*ctrl_pkg::NumBytes-1:0]  wr_active_o,
  output logic [ctrl_pkg::NumRegs*ctrl_pkg::DataWidth-1:0] reg_q_o
);

  import ctrl_pkg::*;

  // Register storage, one byte per entry
  logic [NumRegs-1:0][NumBytes-1:0][7:0] reg_q;

  // Write address and data path
  logic [2:0]                       wr_idx;
  logic                             wr_in_range;
  logic                             wr_hsk;
  logic                             wr_ro_hit;
  logic [NumRegs-1:0][NumBytes-1:0] wr_en;
  axi_resp_e                        wr_resp;

  // Write response channel
  logic      b_valid_q;
  axi_resp_e b_resp_q;

  // Read address path
  logic [2:0]           rd_idx;
  logic                 rd_in_range;
  logic                 rd_hsk;
  logic [DataWidth-1:0] rd_data;
  axi_resp_e            rd_resp;

  // Read data channel
  logic                 r_valid_q;
  logic [DataWidth-1:0] r_data_q;
  axi_resp_e            r_resp_q;

  // Address decode
  // Bits [4:2] pick the register, byte offset is ignored
  assign wr_idx      = axi_req_i.aw_addr[4:2];
  assign rd_idx      = axi_req_i.ar_addr[4:2];
  assign wr_in_range = axi_req_i.aw_addr < AddrWidth'(NumRegs * NumBytes);
  assign rd_in_range = axi_req_i.ar_addr < AddrWidth'(NumRegs * NumBytes);

  // AW and W are taken together, only with no B response outstanding
  assign wr_hsk = axi_req_i.aw_valid & axi_req_i.w_valid & ~b_valid_q;

  // One read in flight at a time
  assign rd_hsk = axi_req_i.ar_valid & ~r_valid_q;

  // Byte enables after the read-only mask
  always_comb begin
    wr_ro_hit = 1'b0;
    wr_en     = '0;
    if (wr_in_range) begin
      wr_ro_hit = |(axi_req_i.w_strb & RegReadOnly[wr_idx]);
      if (wr_hsk) begin
        wr_en[wr_idx] = axi_req_i.w_strb & ~RegReadOnly[wr_idx];
      end
    end
  end

  // Any strobed read-only byte flags an error, the writable bytes still land
  assign wr_resp = (wr_in_range && !wr_ro_hit) ? RESP_OKAY : RESP_SLVERR;

  // Register array
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      reg_q <= RegRstVal;
    end else begin
      for (int r = 0; r < NumRegs; r++) begin
        for (int b = 0; b < NumBytes; b++) begin
          if (wr_en[r][b]) begin
            reg_q[r][b] <= axi_req_i.w_data[8*b +: 8];
          end
        end
      end
    end
  end

  // B valid, held until the master takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_hsk) begin
      b_valid_q <= 1'b1;
    end else if (axi_req_i.b_ready) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_hsk) begin
      b_resp_q <= wr_resp;
    end
  end

  // Read mux
  always_comb begin
    rd_data = '0;
    rd_resp = RESP_SLVERR;
    if (rd_in_range) begin
      rd_data = reg_q[rd_idx];
      rd_resp = RESP_OKAY;
    end
  end

  // R valid, held until the master takes it
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_hsk) begin
      r_valid_q <= 1'b1;
    end else if (axi_req_i.r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  // Sampled at the AR edge, so a same-edge write is not seen
  always_ff @(posedge clk_i) begin
    if (rd_hsk) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  // Response bundle
  always_comb begin
    axi_resp_o.aw_ready = wr_hsk;
    axi_resp_o.w_ready  = wr_hsk;
    axi_resp_o.b_resp   = b_resp_q;
    axi_resp_o.b_valid  = b_valid_q;
    axi_resp_o.ar_ready = rd_hsk;
    axi_resp_o.r_data   = r_data_q;
    axi_resp_o.r_resp   = r_resp_q;
    axi_resp_o.r_valid  = r_valid_q;
  end

  // Strobes of bytes actually written this cycle
  assign wr_active_o = wr_en;
  assign reg_q_o     = reg_q;

endmodule

`default_nettype wire

// ==== hw/ctrl_registers.sv ====
// #####################################
// Cluster control registers
// EOC, wake-up and memory map over AXI-Lite
// #####################################

`timescale 1ns/1ps
`default_nettype none

module ctrl_registers (
  input  logic                              clk_i,
  input  logic                              reset_i,
  // AXI-Lite slave port
  input  ctrl_pkg::axi_lite_req_t           ctrl_req_i,
  output ctrl_pkg::axi_lite_resp_t          ctrl_resp_o,
  // Cluster side
  output logic [ctrl_pkg::DataWidth-1:0]    eoc_o,
  output logic                              eoc_valid_o,
  output logic [ctrl_pkg::NumCores-1:0]     wake_up_o,
  output logic [ctrl_pkg::DataWidth-1:0]    tcdm_start_address_o,
  output logic [ctrl_pkg::DataWidth-1:0]    tcdm_end_address_o,
  output logic [ctrl_pkg::DataWidth-1:0]    num_cores_o
);

  import ctrl_pkg::*;

  logic [NumRegs-1:0][DataWidth-1:0] reg_q;
  logic [NumRegs-1:0][NumBytes-1:0]  wr_active_d;
  logic [NumRegs-1:0][NumBytes-1:0]  wr_active_q;

  logic [DataWidth-1:0] eoc;
  logic [DataWidth-1:0] wake_up;

  axi_lite_regs i_axi_lite_regs (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .axi_req_i  (ctrl_req_i),
    .axi_resp_o (ctrl_resp_o),
    .wr_active_o(wr_active_d),
    .reg_q_o    (reg_q)
  );

  // Register slices
  assign eoc                  = reg_q[REG_EOC];
  assign wake_up              = reg_q[REG_WAKE_UP];
  assign tcdm_start_address_o = reg_q[REG_TCDM_START];
  assign tcdm_end_address_o   = reg_q[REG_TCDM_END];
  assign num_cores_o          = reg_q[REG_NUM_CORES];

  // Delay strobes by one cycle so the decode sees the new wake-up value
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_active_q <= '0;
    end else begin
      wr_active_q <= wr_active_d;
    end
  end

  // Wake-up decode
  // Index below NumCores wakes one core, all ones wakes every core
  always_comb begin
    wake_up_o = '0;
    if (|wr_active_q[REG_WAKE_UP]) begin
      if (wake_up == {DataWidth{1'b1}}) begin
        wake_up_o = {NumCores{1'b1}};
      end else begin
        for (int c = 0; c < NumCores; c++) begin
          wake_up_o[c] = (wake_up == DataWidth'(c));
        end
      end
    end
  end

  // End of computation, bit 0 flags valid, upper bits carry the return code
  assign eoc_o       = eoc >> 1;
  assign eoc_valid_o = eoc[0];

endmodule

`default_nettype wire

// ==== tests/ctrl_registers_properties.sv ====
// ######################################
// Cluster control register assertions
// AXI-Lite response hold and wake-up pulses
// ######################################

`timescale 1ns/1ps
`default_nettype none

module ctrl_registers_properties (
  input logic                          clk_i,
  input logic                          reset_i,
  input ctrl_pkg::axi_lite_req_t       ctrl_req_i,
  input ctrl_pkg::axi_lite_resp_t      ctrl_resp_o,
  input logic [ctrl_pkg::NumCores-1:0] wake_up_o
);

  import ctrl_pkg::*;

  logic        aw_hsk;
  int unsigned b_fails = 0;
  int unsigned r_fails = 0;
  int unsigned shape_fails = 0;
  int unsigned time_fails = 0;
  int unsigned fail_count;

  assign aw_hsk     = ctrl_req_i.aw_valid & ctrl_resp_o.aw_ready;
  assign fail_count = b_fails + r_fails + shape_fails + time_fails;

  // B response holds while the master stalls
  b_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_resp_o.b_valid && !ctrl_req_i.b_ready |=>
      ctrl_resp_o.b_valid && $stable(ctrl_resp_o.b_resp))
    else begin
      $error("B response changed while b_ready was low");
      b_fails++;
    end

  // Same for the read data channel
  r_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
    ctrl_resp_o.r_valid && !ctrl_req_i.r_ready |=>
      ctrl_resp_o.r_valid && $stable(ctrl_resp_o.r_data) && $stable(ctrl_resp_o.r_resp))
    else begin
      $error("R response changed while r_ready was low");
      r_fails++;
    end

  // Single core or broadcast
  wake_shape_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(wake_up_o) || (wake_up_o == '1))
    else begin
      $error("wake_up_o is neither one-hot nor all ones");
      shape_fails++;
    end

  // Pulse only right after a write handshake
  wake_time_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (wake_up_o != '0) |-> $past(aw_hsk))
    else begin
      $error("wake_up_o set without a write handshake in the previous cycle");
      time_fails++;
    end

endmodule

bind ctrl_registers ctrl_registers_properties i_props (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .ctrl_req_i (ctrl_req_i),
  .ctrl_resp_o(ctrl_resp_o),
  .wake_up_o  (wake_up_o)
);

`default_nettype wire

// ==== tests/ctrl_registers_tb.sv ====
// ######################################
// Cluster control register testbench
// AXI-Lite traffic against a register model
// ######################################

`timescale 1ns/1ps
`default_nettype none

module ctrl_registers_tb;

  import ctrl_pkg::*;

  localparam int Timeout        = 40;
  localparam int WatchdogCycles = 20000;

  typedef struct packed {
    logic [31:0] value;
    logic [1:0]  resp;
  } access_result_t;

  logic                clk_i;
  logic                reset_i;
  axi_lite_req_t       ctrl_req;
  axi_lite_resp_t      ctrl_resp;
  logic [31:0]         eoc;
  logic                eoc_valid;
  logic [NumCores-1:0] wake_up;
  logic [31:0]         tcdm_start;
  logic [31:0]         tcdm_end;
  logic [31:0]         num_cores;

  // Register model and pending checks
  logic [31:0] model_regs [NumRegs];
  string       chk_name_q [$];
  logic [31:0] chk_exp_q  [$];
  logic [31:0] chk_act_q  [$];

  int   mismatch_count;
  int   timeout_count;
  int   wake_cycles;
  int   seed;
  logic test_done;
  logic test_abort;

  ctrl_registers dut0 (
    .clk_i               (clk_i),
    .reset_i             (reset_i),
    .ctrl_req_i          (ctrl_req),
    .ctrl_resp_o         (ctrl_resp),
    .eoc_o               (eoc),
    .eoc_valid_o         (eoc_valid),
    .wake_up_o           (wake_up),
    .tcdm_start_address_o(tcdm_start),
    .tcdm_end_address_o  (tcdm_end),
    .num_cores_o         (num_cores)
  );

  always #10 clk_i = ~clk_i;

  // Counts every cycle with a wake-up pulse
  always @(negedge clk_i) begin
    if (!reset_i && wake_up != '0) begin
      wake_cycles++;
    end
  end

  always @(negedge clk_i) begin
    string       name;
    logic [31:0] exp_val;
    logic [31:0] act_val;
    while (chk_act_q.size() != 0) begin
      name    = chk_name_q.pop_front();
      exp_val = chk_exp_q.pop_front();
      act_val = chk_act_q.pop_front();
      assert (act_val === exp_val) else begin
        $display("MISMATCH %s: expected %h, got %h", name, exp_val, act_val);
        mismatch_count++;
      end
    end
  end

  task automatic expect_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
    chk_name_q.push_back(name);
    chk_exp_q.push_back(exp_val);
    chk_act_q.push_back(act_val);
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timed out waiting for %s", what);
    timeout_count++;
    test_abort = 1'b1;
  endtask

  // Expected register value and response of a write
  function automatic access_result_t model_write(input logic [31:0] addr,
                                                 input logic [31:0] data,
                                                 input logic [3:0] strb);
    access_result_t res;
    res.value = '0;
    res.resp  = RESP_OKAY;
    if (addr >= 32'(NumRegs * 4)) begin
      res.resp = RESP_SLVERR;
    end else begin
      res.value = model_regs[addr[4:2]];
      if (addr[4:2] >= 3'd2) begin
        // Start, end and core count take no byte
        if (strb != 4'b0) begin
          res.resp = RESP_SLVERR;
        end
      end else begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            res.value[8*b +: 8] = data[8*b +: 8];
          end
        end
      end
    end
    return res;
  endfunction

  function automatic access_result_t model_read(input logic [31:0] addr);
    access_result_t res;
    res.value = '0;
    res.resp  = RESP_SLVERR;
    if (addr < 32'(NumRegs * 4)) begin
      res.value = model_regs[addr[4:2]];
      res.resp  = RESP_OKAY;
    end
    return res;
  endfunction

  function automatic logic [NumCores-1:0] wake_expected(input logic [31:0] value);
    logic [NumCores-1:0] pulse;
    pulse = '0;
    if (value == 32'hFFFF_FFFF) begin
      pulse = '1;
    end else if (value < 32'(NumCores)) begin
      pulse[value[2:0]] = 1'b1;
    end
    return pulse;
  endfunction

  // bp is the number of cycles b_ready stays low once b_valid is up
  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int bp,
                           output logic [1:0] resp, output logic [NumCores-1:0] wake);
    int n;
    resp = '0;
    wake = '0;
    @(posedge clk_i);
    #2;
    ctrl_req.aw_addr  = addr;
    ctrl_req.aw_valid = 1'b1;
    ctrl_req.w_data   = data;
    ctrl_req.w_strb   = strb;
    ctrl_req.w_valid  = 1'b1;
    ctrl_req.b_ready  = (bp == 0);
    n = 0;
    @(negedge clk_i);
    while (!ctrl_resp.aw_ready && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (!ctrl_resp.aw_ready) begin
      report_timeout("the write address handshake");
      return;
    end
    // W is accepted in the same cycle as AW
    expect_value("w_ready", 32'd1, 32'(ctrl_resp.w_ready));
    @(posedge clk_i);
    #2;
    ctrl_req.aw_valid = 1'b0;
    ctrl_req.w_valid  = 1'b0;
    // First B cycle carries the wake-up pulse
    @(negedge clk_i);
    wake = wake_up;
    resp = ctrl_resp.b_resp;
    expect_value("b_valid", 32'd1, 32'(ctrl_resp.b_valid));
    for (int i = 0; i < bp; i++) begin
      @(negedge clk_i);
      expect_value("b_valid", 32'd1, 32'(ctrl_resp.b_valid));
      expect_value("b_resp", 32'(resp), 32'(ctrl_resp.b_resp));
    end
    if (bp != 0) begin
      @(posedge clk_i);
      #2;
      ctrl_req.b_ready = 1'b1;
    end
    @(posedge clk_i);
    #2;
    ctrl_req.b_ready = 1'b0;
    expect_value("b_valid", 32'd0, 32'(ctrl_resp.b_valid));
  endtask

  task automatic axi_read(input logic [31:0] addr, input int bp,
                          output logic [31:0] data, output logic [1:0] resp);
    int n;
    data = '0;
    resp = '0;
    @(posedge clk_i);
    #2;
    ctrl_req.ar_addr  = addr;
    ctrl_req.ar_valid = 1'b1;
    ctrl_req.r_ready  = (bp == 0);
    n = 0;
    @(negedge clk_i);
    while (!ctrl_resp.ar_ready && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (!ctrl_resp.ar_ready) begin
      report_timeout("the read address handshake");
      return;
    end
    @(posedge clk_i);
    #2;
    ctrl_req.ar_valid = 1'b0;
    @(negedge clk_i);
    data = ctrl_resp.r_data;
    resp = ctrl_resp.r_resp;
    expect_value("r_valid", 32'd1, 32'(ctrl_resp.r_valid));
    for (int i = 0; i < bp; i++) begin
      @(negedge clk_i);
      expect_value("r_valid", 32'd1, 32'(ctrl_resp.r_valid));
      expect_value("r_data", data, ctrl_resp.r_data);
      expect_value("r_resp", 32'(resp), 32'(ctrl_resp.r_resp));
    end
    if (bp != 0) begin
      @(posedge clk_i);
      #2;
      ctrl_req.r_ready = 1'b1;
    end
    @(posedge clk_i);
    #2;
    ctrl_req.r_ready = 1'b0;
    expect_value("r_valid", 32'd0, 32'(ctrl_resp.r_valid));
  endtask

  task automatic write_and_check(input logic [31:0] addr, input logic [31:0] data,
                                 input logic [3:0] strb, input int bp);
    access_result_t      exp;
    logic [1:0]          resp;
    logic [NumCores-1:0] wake;
    logic [NumCores-1:0] wake_exp;
    int                  wake_before;
    exp      = model_write(addr, data, strb);
    wake_exp = '0;
    if (addr < 32'(NumRegs * 4) && addr[4:2] == REG_WAKE_UP && strb != 4'b0) begin
      wake_exp = wake_expected(exp.value);
    end
    wake_before = wake_cycles;
    axi_write(addr, data, strb, bp, resp, wake);
    if (addr < 32'(NumRegs * 4)) begin
      model_regs[addr[4:2]] = exp.value;
    end
    // One more cycle so a stretched pulse would be counted
    @(posedge clk_i);
    #2;
    expect_value("b_resp", 32'(exp.resp), 32'(resp));
    expect_value("wake_up_o", 32'(wake_exp), 32'(wake));
    expect_value("wake_up_o cycles", (wake_exp != '0) ? 32'd1 : 32'd0,
                 32'(wake_cycles - wake_before));
    expect_value("eoc_o", model_regs[0] >> 1, eoc);
    expect_value("eoc_valid_o", 32'(model_regs[0][0]), 32'(eoc_valid));
  endtask

  task automatic read_and_check(input logic [31:0] addr, input int bp);
    access_result_t exp;
    logic [31:0]    data;
    logic [1:0]     resp;
    exp = model_read(addr);
    axi_read(addr, bp, data, resp);
    expect_value("r_data", exp.value, data);
    expect_value("r_resp", 32'(exp.resp), 32'(resp));
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] data;
    int          bp_w;
    int          bp_r;
    seed           = 32'h6c22;
    mismatch_count = 0;
    timeout_count  = 0;
    wake_cycles    = 0;
    test_done      = 1'b0;
    test_abort     = 1'b0;
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    ctrl_req       = '0;
    model_regs[0]  = '0;
    model_regs[1]  = '0;
    model_regs[2]  = TcdmBaseAddr;
    model_regs[3]  = TcdmBaseAddr + TcdmSize;
    model_regs[4]  = 32'(NumCores);
    repeat (3) @(posedge clk_i);
    #2;
    reset_i = 1'b0;

    // Reset state
    @(negedge clk_i);
    expect_value("aw_ready", 32'd0, 32'(ctrl_resp.aw_ready));
    expect_value("w_ready", 32'd0, 32'(ctrl_resp.w_ready));
    expect_value("ar_ready", 32'd0, 32'(ctrl_resp.ar_ready));
    expect_value("b_valid", 32'd0, 32'(ctrl_resp.b_valid));
    expect_value("r_valid", 32'd0, 32'(ctrl_resp.r_valid));
    expect_value("wake_up_o", 32'd0, 32'(wake_up));
    expect_value("eoc_valid_o", 32'd0, 32'(eoc_valid));
    expect_value("tcdm_start_address_o", model_regs[2], tcdm_start);
    expect_value("tcdm_end_address_o", model_regs[3], tcdm_end);
    expect_value("num_cores_o", model_regs[4], num_cores);
    for (int r = 0; r < 5; r++) begin
      read_and_check(32'(4 * r), 0);
    end

    // Random data and strobes on EOC and wake-up
    for (int i = 0; i < 16; i++) begin
      rnd  = $random(seed);
      addr = {29'd0, rnd[0], 2'b00};
      data = $random(seed);
      rnd  = $random(seed);
      write_and_check(addr, data, rnd[3:0], 0);
      read_and_check(addr, 0);
    end

    // Read-only registers and out-of-range addresses
    for (int r = 2; r < 5; r++) begin
      data = $random(seed);
      rnd  = $random(seed);
      write_and_check(32'(4 * r), data, 4'hF, 0);
      write_and_check(32'(4 * r), ~data, rnd[3:0] | 4'h1, 0);
      read_and_check(32'(4 * r), 0);
    end
    read_and_check(32'h14, 0);
    read_and_check(32'h20, 0);
    read_and_check(32'h0001_0000, 0);
    read_and_check(32'h7, 0);
    write_and_check(32'h18, 32'hDEAD_BEEF, 4'hF, 0);
    write_and_check(32'h20, 32'h1234_5678, 4'hF, 0);
    read_and_check(32'h0, 0);

    // Wake-up decode
    for (int k = 0; k < 8; k++) begin
      write_and_check(32'h4, 32'(k), 4'hF, 0);
    end
    write_and_check(32'h4, 32'hFFFF_FFFF, 4'hF, 0);
    write_and_check(32'h4, 32'(NumCores), 4'hF, 0);
    write_and_check(32'h4, 32'h0000_0100, 4'hF, 0);
    write_and_check(32'h4, 32'h8000_0003, 4'hF, 0);
    write_and_check(32'h4, 32'h0000_0002, 4'h1, 0);
    write_and_check(32'h4, 32'h0000_0005, 4'h0, 0);

    // End of computation
    write_and_check(32'h0, 32'h0000_0001, 4'hF, 0);
    write_and_check(32'h0, 32'hABCD_0007, 4'hF, 0);
    write_and_check(32'h0, 32'h0000_0002, 4'hF, 0);

    // Back-pressure on both response channels
    for (int i = 0; i < 24; i++) begin
      rnd  = $random(seed);
      addr = {27'd0, rnd[4:2], 2'b00};
      bp_w = {$random(seed)} % 6;
      bp_r = {$random(seed)} % 6;
      data = $random(seed);
      rnd  = $random(seed);
      write_and_check(addr, data, rnd[3:0], bp_w);
      read_and_check(addr, bp_r);
    end
    test_done = 1'b1;
  end

  initial begin : watchdog_report
    int          cycles;
    int          n;
    int unsigned prop_fails;
    cycles = 0;
    @(posedge clk_i);
    while (!test_done && !test_abort && cycles < WatchdogCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    if (!test_done && !test_abort) begin
      $display("ERROR: simulation did not finish within %0d cycles", WatchdogCycles);
      timeout_count++;
    end
    n = 0;
    while (chk_act_q.size() != 0 && n < Timeout) begin
      @(negedge clk_i);
      n++;
    end
    if (chk_act_q.size() != 0) begin
      $display("ERROR: %0d checks were never evaluated", chk_act_q.size());
      timeout_count++;
    end
    prop_fails = dut0.i_props.fail_count;
    $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatch_count, timeout_count, prop_fails);
    if (mismatch_count == 0 && timeout_count == 0 && prop_fails == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/ctrl_pkg.sv
hw/axi_lite_regs.sv
hw/ctrl_registers.sv
tests/ctrl_registers_properties.sv
tests/ctrl_registers_tb.sv

// ==== Makefile ====
# Verilator flow for the cluster control registers

TOP := ctrl_registers_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	@if grep -qF "*** TEST FAILED ***" sim.log || ! grep -qF "*** TEST PASSED ***" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	fi

lint:
	verilator --lint-only hw/ctrl_pkg.sv hw/axi_lite_regs.sv hw/ctrl_registers.sv \
		--top-module ctrl_registers

clean:
	rm -rf obj_dir sim.log
